// File: project.f
rtl/povPkg.sv
rtl/povIf.sv
rtl/spiFrameReceiver.sv
rtl/povRegisters.sv
rtl/columnSweep.sv
rtl/rayDirGen.sv
rtl/raycastFrontEnd.sv
tb/raycastFrontEnd_asserts.sv
tb/raycastFrontEnd_tb.sv

// File: rtl/columnSweep.sv
`timescale 1ns/1ps
`default_nettype none

module columnSweep (
  input  logic        clk,
  input  logic        reset,
  output povPkg::colT col,
  output povPkg::fixT cameraX,
  output logic        colValid,
  output logic        sweepEnd
);
  import povPkg::*;

  // Column index placed at the bit that gives a step of 2 / SCREEN_COLS
  fixT colScaled;

  // Valid comes up on the first edge after reset and stays there
  always_ff @(posedge clk) begin
    if (reset) begin
      colValid <= 1'b0;
    end else begin
      colValid <= 1'b1;
    end
  end

  // Column 0 is presented first, then one column per cycle without pause
  // The counter width matches the screen so it wraps by itself
  always_ff @(posedge clk) begin
    if (reset) begin
      col <= '0;
    end else if (colValid) begin
      col <= col + 1'b1;
    end
  end

  // Camera plane coordinate runs from -1 at the left edge toward +1
  // Both terms are exact in Q12.12, so no rounding is needed
  assign colScaled = fixT'(col) << CAM_SHIFT;
  assign cameraX = colScaled - FIX_ONE;

  // Marks the last column so a pending frame can go live for the next sweep
  assign sweepEnd = colValid & (col == LAST_COL);

endmodule

`default_nettype wire

// File: rtl/povIf.sv
`timescale 1ns/1ps
`default_nettype none

interface povIf ();
  import povPkg::*;

  // Live point of view, already truncated to output precision
  fixT playerX;
  fixT playerY;
  fixT facingX;
  fixT facingY;
  fixT vplaneX;
  fixT vplaneY;

  // The register block owns all six vectors
  modport source (
    output playerX, playerY, facingX, facingY, vplaneX, vplaneY
  );

  // Ray generation only needs the direction vectors
  modport sink (
    input facingX, facingY, vplaneX, vplaneY
  );

endinterface

`default_nettype wire

// File: rtl/povPkg.sv
`default_nettype none

package povPkg;

  // Every vector is signed Q12.12: 12 integer bits above 12 fraction bits
  localparam int FIELD_BITS = 24;
  localparam int FRAC_BITS = 12;
  localparam int PROD_BITS = 2 * FIELD_BITS;
  localparam int NUM_FIELDS = 6;
  localparam int FRAME_BITS = NUM_FIELDS * FIELD_BITS;
  localparam int BIT_COUNT_BITS = $clog2(FRAME_BITS);

  typedef logic signed [FIELD_BITS-1:0] fixT;
  typedef logic [FRAME_BITS-1:0] frameT;

  // Field order on the wire, field 0 sits at the top of the frame
  localparam int FIELD_PLAYER_X = 0;
  localparam int FIELD_PLAYER_Y = 1;
  localparam int FIELD_FACING_X = 2;
  localparam int FIELD_FACING_Y = 3;
  localparam int FIELD_VPLANE_X = 4;
  localparam int FIELD_VPLANE_Y = 5;

  // Player sits in the middle of map cell (1,1), facing +Y with a narrow view plane
  localparam fixT FIX_ONE = 24'sh001000;
  localparam fixT PLAYER_X_START = 24'sh001800;
  localparam fixT PLAYER_Y_START = 24'sh001800;
  localparam fixT FACING_X_START = 24'sh000000;
  localparam fixT FACING_Y_START = 24'sh001000;
  localparam fixT VPLANE_X_START = 24'shFFF800;
  localparam fixT VPLANE_Y_START = 24'sh000000;

  // Output precision: integer bits kept for positions and vectors, fraction bits kept
  localparam int PLAYER_INT_KEEP = 6;
  localparam int VEC_INT_KEEP = 1;
  localparam int FRAC_KEEP = 9;

  // Screen sweep, cameraX = col / 8 - 1 so the column sits at bit CAM_SHIFT
  localparam int SCREEN_COLS = 16;
  localparam int COL_BITS = 4;
  localparam int CAM_SHIFT = FRAC_BITS + 1 - COL_BITS;

  typedef logic [COL_BITS-1:0] colT;

  localparam colT LAST_COL = colT'(SCREEN_COLS - 1);

  // Picks field k out of a frame, counting from the top
  function automatic fixT fieldOf(frameT f, int k);
    return f[FRAME_BITS-1-k*FIELD_BITS -: FIELD_BITS];
  endfunction

  // Position gives a 64-unit map range at 1/512 unit steps
  function automatic fixT truncPlayer(fixT v);
    return {{(FIELD_BITS-FRAC_BITS-PLAYER_INT_KEEP){v[FIELD_BITS-1]}},
            v[FRAC_BITS+PLAYER_INT_KEEP-1:FRAC_BITS-FRAC_KEEP],
            {(FRAC_BITS-FRAC_KEEP){1'b0}}};
  endfunction

  // Direction vectors only need the range -2.0 up to 2.0
  function automatic fixT truncVector(fixT v);
    return {{(FIELD_BITS-FRAC_BITS-VEC_INT_KEEP){v[FIELD_BITS-1]}},
            v[FRAC_BITS+VEC_INT_KEEP-1:FRAC_BITS-FRAC_KEEP],
            {(FRAC_BITS-FRAC_KEEP){1'b0}}};
  endfunction

endpackage

`default_nettype wire

// File: rtl/povRegisters.sv
`timescale 1ns/1ps
`default_nettype none

module povRegisters (
  input  logic          clk,
  input  logic          reset,
  input  povPkg::frameT frame,
  input  logic          frameDone,
  input  logic          sweepEnd,
  povIf.source          pov,
  output logic          povLoaded
);
  import povPkg::*;

  // Last complete frame waiting for the end of a sweep
  frameT pendingFrame;
  logic pendingValid;
  logic loadNow;

  // Live vectors at full Q12.12 precision
  fixT playerXReg;
  fixT playerYReg;
  fixT facingXReg;
  fixT facingYReg;
  fixT vplaneXReg;
  fixT vplaneYReg;

  // Only swap at the end of a sweep so no sweep mixes old and new views
  assign loadNow = sweepEnd & pendingValid;

  always_ff @(posedge clk) begin
    if (frameDone) begin
      pendingFrame <= frame;
    end
  end

  // A frame arriving on a load cycle stays pending, the load takes the older one
  always_ff @(posedge clk) begin
    if (reset) begin
      pendingValid <= 1'b0;
    end else if (frameDone) begin
      pendingValid <= 1'b1;
    end else if (loadNow) begin
      pendingValid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      playerXReg <= PLAYER_X_START;
      playerYReg <= PLAYER_Y_START;
      facingXReg <= FACING_X_START;
      facingYReg <= FACING_Y_START;
      vplaneXReg <= VPLANE_X_START;
      vplaneYReg <= VPLANE_Y_START;
    end else if (loadNow) begin
      playerXReg <= fieldOf(pendingFrame, FIELD_PLAYER_X);
      playerYReg <= fieldOf(pendingFrame, FIELD_PLAYER_Y);
      facingXReg <= fieldOf(pendingFrame, FIELD_FACING_X);
      facingYReg <= fieldOf(pendingFrame, FIELD_FACING_Y);
      vplaneXReg <= fieldOf(pendingFrame, FIELD_VPLANE_X);
      vplaneYReg <= fieldOf(pendingFrame, FIELD_VPLANE_Y);
    end
  end

  // High for the first cycle the new vectors are live
  always_ff @(posedge clk) begin
    if (reset) begin
      povLoaded <= 1'b0;
    end else begin
      povLoaded <= loadNow;
    end
  end

  // Outputs are cut down to the precision the renderer uses
  assign pov.playerX = truncPlayer(playerXReg);
  assign pov.playerY = truncPlayer(playerYReg);
  assign pov.facingX = truncVector(facingXReg);
  assign pov.facingY = truncVector(facingYReg);
  assign pov.vplaneX = truncVector(vplaneXReg);
  assign pov.vplaneY = truncVector(vplaneYReg);

endmodule

`default_nettype wire

// File: rtl/rayDirGen.sv
`timescale 1ns/1ps
`default_nettype none

module rayDirGen (
  input  logic        clk,
  input  logic        reset,
  povIf.sink          pov,
  input  povPkg::colT col,
  input  povPkg::fixT cameraX,
  input  logic        colValid,
  output povPkg::colT rayCol,
  output povPkg::fixT rayDirX,
  output povPkg::fixT rayDirY,
  output logic        rayValid
);
  import povPkg::*;

  // Full Q24.24 products of the view plane with the camera coordinate
  logic signed [PROD_BITS-1:0] prodX;
  logic signed [PROD_BITS-1:0] prodY;

  // Stage 1 holds everything one column needs
  fixT planeXS1;
  fixT planeYS1;
  fixT facingXS1;
  fixT facingYS1;
  colT colS1;
  logic validS1;

  assign prodX = pov.vplaneX * cameraX;
  assign prodY = pov.vplaneY * cameraX;

  // Facing is captured with the products so a load between stages cannot split a column
  // Dropping 12 fraction bits loses nothing given the truncated inputs
  always_ff @(posedge clk) begin
    planeXS1 <= prodX[FRAC_BITS +: FIELD_BITS];
    planeYS1 <= prodY[FRAC_BITS +: FIELD_BITS];
    facingXS1 <= pov.facingX;
    facingYS1 <= pov.facingY;
    colS1 <= col;
  end

  // Ray direction is facing plus the scaled plane, wrapping in 24 bits
  always_ff @(posedge clk) begin
    rayDirX <= facingXS1 + planeXS1;
    rayDirY <= facingYS1 + planeYS1;
    rayCol <= colS1;
  end

  // Valid travels alongside the data, two cycles end to end
  always_ff @(posedge clk) begin
    if (reset) begin
      validS1 <= 1'b0;
      rayValid <= 1'b0;
    end else begin
      validS1 <= colValid;
      rayValid <= validS1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/raycastFrontEnd.sv
`timescale 1ns/1ps
`default_nettype none

module raycastFrontEnd (
  input  logic        clk,
  input  logic        reset,
  input  logic        sclk,
  input  logic        ssN,
  input  logic        mosi,
  output povPkg::fixT playerX,
  output povPkg::fixT playerY,
  output povPkg::colT rayCol,
  output povPkg::fixT rayDirX,
  output povPkg::fixT rayDirY,
  output logic        rayValid,
  output logic        povLoaded
);
  import povPkg::*;

  // Received frame handed to the double buffer
  frameT frame;
  logic frameDone;

  // Column sweep outputs
  colT col;
  fixT cameraX;
  logic colValid;
  logic sweepEnd;

  // Live point of view shared by the register block and ray generation
  povIf povBus ();

  spiFrameReceiver i_spiFrameReceiver (
    .clk       (clk),
    .reset     (reset),
    .sclk      (sclk),
    .ssN       (ssN),
    .mosi      (mosi),
    .frame     (frame),
    .frameDone (frameDone)
  );

  povRegisters i_povRegisters (
    .clk       (clk),
    .reset     (reset),
    .frame     (frame),
    .frameDone (frameDone),
    .sweepEnd  (sweepEnd),
    .pov       (povBus.source),
    .povLoaded (povLoaded)
  );

  columnSweep i_columnSweep (
    .clk      (clk),
    .reset    (reset),
    .col      (col),
    .cameraX  (cameraX),
    .colValid (colValid),
    .sweepEnd (sweepEnd)
  );

  rayDirGen i_rayDirGen (
    .clk      (clk),
    .reset    (reset),
    .pov      (povBus.sink),
    .col      (col),
    .cameraX  (cameraX),
    .colValid (colValid),
    .rayCol   (rayCol),
    .rayDirX  (rayDirX),
    .rayDirY  (rayDirY),
    .rayValid (rayValid)
  );

  // Player position goes straight out for the map walk downstream
  assign playerX = povBus.playerX;
  assign playerY = povBus.playerY;

endmodule

`default_nettype wire

// File: rtl/spiFrameReceiver.sv
`timescale 1ns/1ps
`default_nettype none

module spiFrameReceiver (
  input  logic          clk,
  input  logic          reset,
  input  logic          sclk,
  input  logic          ssN,
  input  logic          mosi,
  output povPkg::frameT frame,
  output logic          frameDone
);
  import povPkg::*;

  // SCLK needs a third stage so stages 1 and 2 can be compared for a rising edge
  logic [2:0] sclkSync;
  // Select and data are only sampled as levels, two stages each
  logic [1:0] ssSync;
  logic [1:0] mosiSync;

  logic sclkRise;
  logic ssActive;
  logic mosiBit;

  logic [BIT_COUNT_BITS-1:0] bitCount;
  logic lastBit;
  logic shiftEn;
  frameT shiftReg;

  always_ff @(posedge clk) begin
    if (reset) begin
      sclkSync <= '0;
      // Select idles high so nothing is counted while leaving reset
      ssSync <= 2'b11;
      mosiSync <= '0;
    end else begin
      sclkSync <= {sclkSync[1:0], sclk};
      ssSync <= {ssSync[0], ssN};
      mosiSync <= {mosiSync[0], mosi};
    end
  end

  assign sclkRise = (sclkSync[2:1] == 2'b01);
  assign ssActive = ~ssSync[1];
  assign mosiBit = mosiSync[1];

  // A bit is taken on every SCLK rise seen while the slave is selected
  assign shiftEn = ssActive & sclkRise;
  assign lastBit = (bitCount == BIT_COUNT_BITS'(FRAME_BITS - 1));

  // Deselect drops a partial frame
  // With select held low the count wraps so frames can follow back to back
  always_ff @(posedge clk) begin
    if (reset) begin
      bitCount <= '0;
    end else if (!ssActive) begin
      bitCount <= '0;
    end else if (sclkRise) begin
      if (lastBit) begin
        bitCount <= '0;
      end else begin
        bitCount <= bitCount + 1'b1;
      end
    end
  end

  // MSB first, so each new bit enters at the bottom
  always_ff @(posedge clk) begin
    if (shiftEn) begin
      shiftReg <= {shiftReg[FRAME_BITS-2:0], mosiBit};
    end
  end

  // The finished frame is copied on the same edge that raises frameDone
  always_ff @(posedge clk) begin
    if (shiftEn && lastBit) begin
      frame <= {shiftReg[FRAME_BITS-2:0], mosiBit};
    end
  end

  // One-cycle pulse after the final bit is sampled
  always_ff @(posedge clk) begin
    if (reset) begin
      frameDone <= 1'b0;
    end else begin
      frameDone <= shiftEn & lastBit;
    end
  end

endmodule

`default_nettype wire

// File: tb/raycastFrontEnd_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module raycastFrontEnd_asserts (
  input logic          clk,
  input logic          reset,
  input logic          sweepEnd,
  input logic          pendingValid,
  input logic          frameDone,
  input logic          povLoaded,
  input povPkg::frameT liveVec
);
  import povPkg::*;

  // The live vectors may only move on the edge right after a sweep end with a frame pending
  liveChangeOnLoad: assert property (
    @(posedge clk) disable iff (reset)
    !$stable(liveVec) |-> $past(sweepEnd && pendingValid)
  ) else $error("Live vectors changed outside a sweep-end load");

  // The load pulse follows the last column of a sweep
  loadAfterSweepEnd: assert property (
    @(posedge clk) disable iff (reset)
    povLoaded |-> $past(sweepEnd)
  ) else $error("povLoaded pulsed without sweepEnd on the cycle before");

  // Only a finished frame can make the buffer pending
  pendingAfterFrame: assert property (
    @(posedge clk) disable iff (reset)
    $rose(pendingValid) |-> $past(frameDone)
  ) else $error("Pending flag rose without frameDone on the cycle before");

endmodule

`default_nettype wire

// File: tb/raycastFrontEnd_tb.sv
`timescale 1ns/1ps
`default_nettype none

module raycastFrontEnd_tb;
  import povPkg::*;

  logic clk = 1'b0;
  logic reset;
  logic sclk;
  logic ssN;
  logic mosi;
  fixT playerX;
  fixT playerY;
  colT rayCol;
  fixT rayDirX;
  fixT rayDirY;
  logic rayValid;
  logic povLoaded;

  integer seed;
  int loadCount = 0;
  int beatCount = 0;
  int startLoads;
  bit loadExpected = 1'b0;
  bit raySwitch = 1'b0;
  bit raysStarted = 1'b0;
  // Columns come out in order from column 0 after reset
  colT expCol = '0;
  // Expected vectors are all held as truncated frames
  frameT playerVec;
  frameT rayVec;
  frameT rayNext;
  frameT pendingVec;
  frameT txFrame;
  frameT txFrame2;
  logic [47:0] expRay;

  always #10 clk = ~clk;

  raycastFrontEnd i_raycastFrontEnd (
    .clk(clk), .reset(reset), .sclk(sclk), .ssN(ssN), .mosi(mosi),
    .playerX(playerX), .playerY(playerY), .rayCol(rayCol), .rayDirX(rayDirX),
    .rayDirY(rayDirY), .rayValid(rayValid), .povLoaded(povLoaded)
  );

  bind povRegisters raycastFrontEnd_asserts i_raycastFrontEnd_asserts (
    .clk(clk), .reset(reset), .sweepEnd(sweepEnd), .pendingValid(pendingValid),
    .frameDone(frameDone), .povLoaded(povLoaded),
    .liveVec({playerXReg, playerYReg, facingXReg, facingYReg, vplaneXReg, vplaneYReg})
  );

  task automatic failRun(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Field k counted from the top of the frame
  function automatic fixT fieldAt(frameT f, int k);
    return fixT'(f >> (FIELD_BITS * (NUM_FIELDS - 1 - k)));
  endfunction

  // Positions keep bits 17..3 and vectors keep bits 12..3 while the upper bits copy the sign
  function automatic fixT truncField(fixT v, bit isPlayer);
    logic [23:0] keepMask;
    logic [23:0] signFill;
    keepMask = isPlayer ? 24'h03FFF8 : 24'h001FF8;
    signFill = ~keepMask & 24'hFFFFF8;
    return v[23] ? ((v & keepMask) | signFill) : (v & keepMask);
  endfunction

  function automatic frameT truncFrame(frameT f);
    frameT result;
    result = '0;
    for (int k = 0; k < NUM_FIELDS; k++) begin
      result = {result[FRAME_BITS-FIELD_BITS-1:0], truncField(fieldAt(f, k), k < 2)};
    end
    return result;
  endfunction

  // Ray for column c is facing + vplane * (2c/16 - 1) with all values in units of 2^-12
  function automatic logic [47:0] refRay(int c, frameT v);
    longint cam;
    longint sx;
    longint sy;
    cam = longint'(c) * 512 - 4096;
    sx = longint'(fieldAt(v, 2)) + ((longint'(fieldAt(v, 4)) * cam) >>> 12);
    sy = longint'(fieldAt(v, 3)) + ((longint'(fieldAt(v, 5)) * cam) >>> 12);
    return {sx[23:0], sy[23:0]};
  endfunction

  task automatic tick(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Sends one bit per 8 clk cycles MSB first and the last full bit arms the load check
  task automatic sendBits(input frameT f, input int nBits);
    for (int i = 0; i < nBits; i++) begin
      mosi = f[FRAME_BITS-1-i];
      sclk = 1'b0;
      tick(4);
      sclk = 1'b1;
      if (i == FRAME_BITS - 1) begin
        pendingVec = truncFrame(f);
        loadExpected = 1'b1;
      end
      tick(4);
    end
    sclk = 1'b0;
  endtask

  task automatic randomFrame(output frameT f);
    logic [31:0] r;
    for (int k = 0; k < NUM_FIELDS; k++) begin
      r = $random(seed);
      f = {f[FRAME_BITS-FIELD_BITS-1:0], r[23:0]};
    end
  endtask

  task automatic waitLoads(input int target);
    int waited;
    waited = 0;
    while (loadCount < target) begin
      if (waited > 200) begin
        failRun("Timed out waiting for povLoaded after a complete frame");
      end else begin
        tick(1);
        waited++;
      end
    end
  endtask

  task automatic waitRays();
    int waited;
    waited = 0;
    while (!rayValid) begin
      if (waited > 20) begin
        failRun("Timed out waiting for the first rayValid after reset");
      end else begin
        tick(1);
        waited++;
      end
    end
  endtask

  // Outputs are sampled at the falling edge half a period away from any change
  always @(negedge clk) begin
    if (!reset) begin
      if (povLoaded) begin
        assert (loadExpected) else failRun("povLoaded pulsed with no complete frame sent");
        loadExpected = 1'b0;
        loadCount++;
        playerVec = pendingVec;
        rayNext = pendingVec;
        raySwitch = 1'b1;
      end
      assert (playerX === fieldAt(playerVec, 0)) else begin
        $display("ERR %0t playerX got %h expected %h", $time, playerX, fieldAt(playerVec, 0));
        failRun("playerX mismatch");
      end
      assert (playerY === fieldAt(playerVec, 1)) else begin
        $display("ERR %0t playerY got %h expected %h", $time, playerY, fieldAt(playerVec, 1));
        failRun("playerY mismatch");
      end
      if (rayValid) begin
        assert (rayCol === expCol) else begin
          $display("ERR %0t rayCol got %h expected %h", $time, rayCol, expCol);
          failRun("rayCol out of sequence");
        end
        // Columns still in flight at the load keep the old view until column 0
        if (raySwitch && expCol == '0) begin
          rayVec = rayNext;
          raySwitch = 1'b0;
        end
        expRay = refRay(int'(expCol), rayVec);
        assert (rayDirX === expRay[47:24]) else begin
          $display("ERR %0t rayDirX got %h expected %h", $time, rayDirX, expRay[47:24]);
          failRun("rayDirX mismatch");
        end
        assert (rayDirY === expRay[23:0]) else begin
          $display("ERR %0t rayDirY got %h expected %h", $time, rayDirY, expRay[23:0]);
          failRun("rayDirY mismatch");
        end
        expCol = expCol + 1'b1;
        raysStarted = 1'b1;
        beatCount++;
      end else begin
        // The sweep never pauses, so rays keep coming once they start
        assert (!raysStarted) else failRun("rayValid dropped after the rays had started");
      end
    end
  end

  initial begin
    reset = 1'b1;
    sclk = 1'b0;
    ssN = 1'b1;
    mosi = 1'b0;
    seed = 32'h51d48d33;
    // Start view has the player at 1.5 facing (0, 1) with the plane at (-0.5, 0)
    playerVec = {24'h001800, 24'h001800, 24'h000000, 24'h001000, 24'hFFF800, 24'h000000};
    rayVec = playerVec;
    pendingVec = playerVec;
    tick(3);
    reset = 1'b0;
    waitRays();
    // Column 0 of the start view points at (0.5, 1.0)
    assert (rayDirX === 24'h000800) else begin
      $display("ERR %0t rayDirX got %h expected %h", $time, rayDirX, 24'h000800);
      failRun("First ray after reset has the wrong X direction");
    end
    assert (rayDirY === 24'h001000) else begin
      $display("ERR %0t rayDirY got %h expected %h", $time, rayDirY, 24'h001000);
      failRun("First ray after reset has the wrong Y direction");
    end
    tick(40);

    // A random frame sent with ssN framing is checked through the next sweeps
    randomFrame(txFrame);
    startLoads = loadCount;
    ssN = 1'b0;
    tick(2);
    sendBits(txFrame, FRAME_BITS);
    tick(4);
    ssN = 1'b1;
    waitLoads(startLoads + 1);
    tick(40);

    // Two frames are sent with ssN held low and the second one must end up live
    randomFrame(txFrame);
    randomFrame(txFrame2);
    startLoads = loadCount;
    ssN = 1'b0;
    tick(2);
    sendBits(txFrame, FRAME_BITS);
    sendBits(txFrame2, FRAME_BITS);
    tick(4);
    ssN = 1'b1;
    waitLoads(startLoads + 2);
    tick(40);
    assert (playerX === truncField(fieldAt(txFrame2, 0), 1'b1)) else begin
      $display("ERR %0t playerX got %h expected %h", $time, playerX,
               truncField(fieldAt(txFrame2, 0), 1'b1));
      failRun("Second back-to-back frame is not live");
    end

    // Deselect after 70 bits means nothing may load within two sweeps
    randomFrame(txFrame);
    startLoads = loadCount;
    ssN = 1'b0;
    tick(2);
    sendBits(txFrame, 70);
    ssN = 1'b1;
    tick(2 * SCREEN_COLS + 8);
    assert (loadCount == startLoads) else failRun("An aborted frame was loaded");

    // Negative fields with high integer bits exercise sign extension
    txFrame = {24'hC2A5F7, 24'hFF8123, 24'hA03E09, 24'h7FFFFF, 24'h800001, 24'hE01FFF};
    startLoads = loadCount;
    ssN = 1'b0;
    tick(2);
    sendBits(txFrame, FRAME_BITS);
    tick(4);
    ssN = 1'b1;
    waitLoads(startLoads + 1);
    tick(40);

    if (beatCount > 100) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      failRun("Too few ray beats were checked");
    end
  end

endmodule

`default_nettype wire
